//--- rtl/mem_pkg.sv
package mem_pkg;

  // bus widths
  localparam int addr_width = 32;
  localparam int data_width = 32;

  // one strobe bit per byte lane
  localparam int strb_width = 4;

  // word memory, 4 KiB
  localparam int mem_words = 1024;

  // word index taken from address bits 11:2
  // higher address bits are ignored, so accesses wrap
  localparam int mem_index_width = 10;

  // cache geometry, one word per line
  localparam int icache_lines = 16;
  localparam int dcache_lines = 16;

  // line index from address bits 5:2
  localparam int line_index_width = 4;

  // tag from address bits 31:6
  localparam int tag_width = 26;

endpackage

//--- rtl/axi_memory.sv
`timescale 1ns/1ps

module axi_memory (
  input  logic                           clk,
  input  logic                           reset,

  // read channel a
  input  logic                           a_arvalid,
  output logic                           a_arready,
  input  logic [mem_pkg::addr_width-1:0] a_araddr,
  output logic                           a_rvalid,
  input  logic                           a_rready,
  output logic [mem_pkg::data_width-1:0] a_rdata,

  // read channel b
  input  logic                           b_arvalid,
  output logic                           b_arready,
  input  logic [mem_pkg::addr_width-1:0] b_araddr,
  output logic                           b_rvalid,
  input  logic                           b_rready,
  output logic [mem_pkg::data_width-1:0] b_rdata,

  // write channels
  input  logic                           awvalid,
  output logic                           awready,
  input  logic [mem_pkg::addr_width-1:0] awaddr,
  input  logic                           wvalid,
  output logic                           wready,
  input  logic [mem_pkg::data_width-1:0] wdata,
  input  logic [mem_pkg::strb_width-1:0] wstrb,
  output logic                           bvalid,
  input  logic                           bready
);
  import mem_pkg::*;

  logic [data_width-1:0] mem [mem_words];

  logic [mem_index_width-1:0] a_index;
  logic [mem_index_width-1:0] b_index;
  logic [mem_index_width-1:0] w_index;
  logic                       a_ar_fire;
  logic                       b_ar_fire;
  logic                       w_fire;

  // word index, upper bits dropped for the wrap
  assign a_index = a_araddr[mem_index_width+1:2];
  assign b_index = b_araddr[mem_index_width+1:2];
  assign w_index = awaddr[mem_index_width+1:2];

  // a port takes a new address only with no response pending
  assign a_arready = !a_rvalid;
  assign b_arready = !b_rvalid;

  // address and data accepted together, stalled while a response waits
  assign awready = !bvalid;
  assign wready  = !bvalid;

  assign a_ar_fire = a_arvalid && a_arready;
  assign b_ar_fire = b_arvalid && b_arready;
  assign w_fire    = awvalid && awready && wvalid && wready;

  // byte lane write
  always_ff @(posedge clk) begin
    if (w_fire) begin
      for (int i = 0; i < strb_width; i++) begin
        if (wstrb[i]) begin
          mem[w_index][8*i +: 8] <= wdata[8*i +: 8];
        end
      end
    end
  end

  // read data registers; a same-cycle write is not seen
  always_ff @(posedge clk) begin
    if (a_ar_fire) begin
      a_rdata <= mem[a_index];
    end
    if (b_ar_fire) begin
      b_rdata <= mem[b_index];
    end
  end

  // pending read responses
  always_ff @(posedge clk) begin
    if (reset) begin
      a_rvalid <= 1'b0;
      b_rvalid <= 1'b0;
    end else begin
      if (a_ar_fire) begin
        a_rvalid <= 1'b1;
      end else if (a_rvalid && a_rready) begin
        a_rvalid <= 1'b0;
      end
      if (b_ar_fire) begin
        b_rvalid <= 1'b1;
      end else if (b_rvalid && b_rready) begin
        b_rvalid <= 1'b0;
      end
    end
  end

  // write response
  always_ff @(posedge clk) begin
    if (reset) begin
      bvalid <= 1'b0;
    end else if (w_fire) begin
      bvalid <= 1'b1;
    end else if (bvalid && bready) begin
      bvalid <= 1'b0;
    end
  end

endmodule

//--- rtl/i_cache.sv
`timescale 1ns/1ps

module i_cache (
  input  logic                           clk,
  input  logic                           reset,

  // fetch side
  input  logic [mem_pkg::addr_width-1:0] pc,
  output logic [mem_pkg::data_width-1:0] instruction,
  output logic                           instr_valid,

  // read channel master
  output logic                           arvalid,
  input  logic                           arready,
  output logic [mem_pkg::addr_width-1:0] araddr,
  input  logic                           rvalid,
  output logic                           rready,
  input  logic [mem_pkg::data_width-1:0] rdata
);
  import mem_pkg::*;

  typedef enum logic [1:0] {
    idle,
    request,
    wait_data
  } state_t;

  state_t state;

  logic [tag_width-1:0]  tag_mem  [icache_lines];
  logic [data_width-1:0] data_mem [icache_lines];
  logic [icache_lines-1:0] valid;

  logic [line_index_width-1:0] index;
  logic [tag_width-1:0]        tag;
  logic                        hit;

  logic [addr_width-1:0]       miss_addr;
  logic [line_index_width-1:0] fill_index;
  logic [tag_width-1:0]        fill_tag;

  // lookup on the current pc
  assign index = pc[line_index_width+1:2];
  assign tag   = pc[addr_width-1 -: tag_width];
  assign hit   = valid[index] && (tag_mem[index] == tag);

  assign instruction = data_mem[index];
  assign instr_valid = hit;

  // line being filled
  assign fill_index = miss_addr[line_index_width+1:2];
  assign fill_tag   = miss_addr[addr_width-1 -: tag_width];

  assign arvalid = (state == request);
  assign araddr  = miss_addr;
  assign rready  = (state == wait_data);

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= idle;
    end else begin
      case (state)
        idle: begin
          if (!hit) begin
            state <= request;
          end
        end
        request: begin
          if (arready) begin
            state <= wait_data;
          end
        end
        wait_data: begin
          if (rvalid) begin
            state <= idle;
          end
        end
        default: begin
          state <= idle;
        end
      endcase
    end
  end

  // word-aligned miss address, held through the fill
  always_ff @(posedge clk) begin
    if (state == idle && !hit) begin
      miss_addr <= {pc[addr_width-1:2], 2'b00};
    end
  end

  always_ff @(posedge clk) begin
    if (rvalid && rready) begin
      tag_mem[fill_index]  <= fill_tag;
      data_mem[fill_index] <= rdata;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid <= '0;
    end else if (rvalid && rready) begin
      valid[fill_index] <= 1'b1;
    end
  end

endmodule

//--- rtl/d_cache.sv
`timescale 1ns/1ps

module d_cache (
  input  logic                           clk,
  input  logic                           reset,

  // load/store side
  input  logic [mem_pkg::addr_width-1:0] address,
  input  logic                           read_enable,
  input  logic                           write_enable,
  input  logic [mem_pkg::data_width-1:0] write_data,
  input  logic [mem_pkg::strb_width-1:0] strb,
  output logic [mem_pkg::data_width-1:0] read_data,
  output logic                           read_valid,
  output logic                           write_ready,

  // read channel master
  output logic                           arvalid,
  input  logic                           arready,
  output logic [mem_pkg::addr_width-1:0] araddr,
  input  logic                           rvalid,
  output logic                           rready,
  input  logic [mem_pkg::data_width-1:0] rdata,

  // write channel master
  output logic                           awvalid,
  input  logic                           awready,
  output logic [mem_pkg::addr_width-1:0] awaddr,
  output logic                           wvalid,
  input  logic                           wready,
  output logic [mem_pkg::data_width-1:0] wdata,
  output logic [mem_pkg::strb_width-1:0] wstrb,
  input  logic                           bvalid,
  output logic                           bready
);
  import mem_pkg::*;

  typedef enum logic [2:0] {
    idle,
    rd_req,
    rd_wait,
    wr_req,
    wr_resp
  } state_t;

  state_t state;

  logic [tag_width-1:0]  tag_mem  [dcache_lines];
  logic [data_width-1:0] data_mem [dcache_lines];
  logic [dcache_lines-1:0] valid;

  logic [line_index_width-1:0] index;
  logic [tag_width-1:0]        tag;
  logic                        hit;

  // request captured when leaving idle
  logic [addr_width-1:0]       req_addr;
  logic [data_width-1:0]       req_data;
  logic [strb_width-1:0]       req_strb;
  logic [line_index_width-1:0] req_index;
  logic [tag_width-1:0]        req_tag;
  logic                        req_hit;

  // lookup on the core address
  assign index = address[line_index_width+1:2];
  assign tag   = address[addr_width-1 -: tag_width];
  assign hit   = valid[index] && (tag_mem[index] == tag);

  // a pending store goes first
  assign read_data  = data_mem[index];
  assign read_valid = read_enable && !write_enable && hit;

  assign req_index = req_addr[line_index_width+1:2];
  assign req_tag   = req_addr[addr_width-1 -: tag_width];
  assign req_hit   = valid[req_index] && (tag_mem[req_index] == req_tag);

  assign arvalid = (state == rd_req);
  assign araddr  = req_addr;
  assign rready  = (state == rd_wait);

  // store is forwarded as written
  assign awvalid = (state == wr_req);
  assign wvalid  = (state == wr_req);
  assign awaddr  = req_addr;
  assign wdata   = req_data;
  assign wstrb   = req_strb;
  assign bready  = (state == wr_resp);

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= idle;
    end else begin
      case (state)
        idle: begin
          // write_ready high means this store just finished
          if (write_enable && !write_ready) begin
            state <= wr_req;
          end else if (read_enable && !write_enable && !hit) begin
            state <= rd_req;
          end
        end
        rd_req: begin
          if (arready) begin
            state <= rd_wait;
          end
        end
        rd_wait: begin
          if (rvalid) begin
            state <= idle;
          end
        end
        wr_req: begin
          if (awready && wready) begin
            state <= wr_resp;
          end
        end
        wr_resp: begin
          if (bvalid) begin
            state <= idle;
          end
        end
        default: begin
          state <= idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == idle) begin
      req_addr <= {address[addr_width-1:2], 2'b00};
      req_data <= write_data;
      req_strb <= strb;
    end
  end

  // line fill on a read miss, byte merge on a store hit
  always_ff @(posedge clk) begin
    if (rvalid && rready) begin
      tag_mem[req_index]  <= req_tag;
      data_mem[req_index] <= rdata;
    end else if (bvalid && bready && req_hit) begin
      for (int i = 0; i < strb_width; i++) begin
        if (req_strb[i]) begin
          data_mem[req_index][8*i +: 8] <= req_data[8*i +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid <= '0;
    end else if (rvalid && rready) begin
      valid[req_index] <= 1'b1;
    end
  end

  // one-cycle pulse after the b transfer
  always_ff @(posedge clk) begin
    if (reset) begin
      write_ready <= 1'b0;
    end else begin
      write_ready <= bvalid && bready;
    end
  end

endmodule

//--- rtl/memory_subsystem.sv
`timescale 1ns/1ps

module memory_subsystem (
  input  logic                           clk,
  input  logic                           reset,

  // fetch port
  input  logic [mem_pkg::addr_width-1:0] pc,
  output logic [mem_pkg::data_width-1:0] instruction,
  output logic                           instr_valid,

  // load/store port
  input  logic [mem_pkg::addr_width-1:0] address,
  input  logic                           read_enable,
  output logic [mem_pkg::data_width-1:0] read_data,
  output logic                           read_valid,
  input  logic                           write_enable,
  input  logic [mem_pkg::data_width-1:0] write_data,
  input  logic [mem_pkg::strb_width-1:0] strb,
  output logic                           write_ready
);
  import mem_pkg::*;

  // read channel a, instruction side
  logic                  a_arvalid;
  logic                  a_arready;
  logic [addr_width-1:0] a_araddr;
  logic                  a_rvalid;
  logic                  a_rready;
  logic [data_width-1:0] a_rdata;

  // read channel b, data side
  logic                  b_arvalid;
  logic                  b_arready;
  logic [addr_width-1:0] b_araddr;
  logic                  b_rvalid;
  logic                  b_rready;
  logic [data_width-1:0] b_rdata;

  // write channels
  logic                  awvalid;
  logic                  awready;
  logic [addr_width-1:0] awaddr;
  logic                  wvalid;
  logic                  wready;
  logic [data_width-1:0] wdata;
  logic [strb_width-1:0] wstrb;
  logic                  bvalid;
  logic                  bready;

  i_cache i_cache (
    .clk         (clk),
    .reset       (reset),
    .pc          (pc),
    .instruction (instruction),
    .instr_valid (instr_valid),
    .arvalid     (a_arvalid),
    .arready     (a_arready),
    .araddr      (a_araddr),
    .rvalid      (a_rvalid),
    .rready      (a_rready),
    .rdata       (a_rdata)
  );

  d_cache d_cache (
    .clk          (clk),
    .reset        (reset),
    .address      (address),
    .read_enable  (read_enable),
    .write_enable (write_enable),
    .write_data   (write_data),
    .strb         (strb),
    .read_data    (read_data),
    .read_valid   (read_valid),
    .write_ready  (write_ready),
    .arvalid      (b_arvalid),
    .arready      (b_arready),
    .araddr       (b_araddr),
    .rvalid       (b_rvalid),
    .rready       (b_rready),
    .rdata        (b_rdata),
    .awvalid      (awvalid),
    .awready      (awready),
    .awaddr       (awaddr),
    .wvalid       (wvalid),
    .wready       (wready),
    .wdata        (wdata),
    .wstrb        (wstrb),
    .bvalid       (bvalid),
    .bready       (bready)
  );

  axi_memory axi_memory (
    .clk       (clk),
    .reset     (reset),
    .a_arvalid (a_arvalid),
    .a_arready (a_arready),
    .a_araddr  (a_araddr),
    .a_rvalid  (a_rvalid),
    .a_rready  (a_rready),
    .a_rdata   (a_rdata),
    .b_arvalid (b_arvalid),
    .b_arready (b_arready),
    .b_araddr  (b_araddr),
    .b_rvalid  (b_rvalid),
    .b_rready  (b_rready),
    .b_rdata   (b_rdata),
    .awvalid   (awvalid),
    .awready   (awready),
    .awaddr    (awaddr),
    .wvalid    (wvalid),
    .wready    (wready),
    .wdata     (wdata),
    .wstrb     (wstrb),
    .bvalid    (bvalid),
    .bready    (bready)
  );

endmodule

//--- verification/memory_subsystem_tb.sv
`timescale 1ns/1ps

module memory_subsystem_tb;
  import mem_pkg::*;

  // fetch address used while no fetch test runs
  localparam logic [31:0] park_pc = 32'h0000_0fc0;

  // requests per behavior, used by the watchdog
  localparam int total_ops = 24 + 10 + 24 + 18 + 256 + 200;

  logic                  clk;
  logic                  reset;
  logic [addr_width-1:0] pc;
  logic [data_width-1:0] instruction;
  logic                  instr_valid;
  logic [addr_width-1:0] address;
  logic                  read_enable;
  logic [data_width-1:0] read_data;
  logic                  read_valid;
  logic                  write_enable;
  logic [data_width-1:0] write_data;
  logic [strb_width-1:0] strb;
  logic                  write_ready;

  // byte model of the whole memory
  logic [7:0]  model [mem_words*4];
  logic [31:0] seed;
  int          value_errors;
  int          protocol_errors;
  int          stores_done;
  int          ready_pulses;

  memory_subsystem DUT (
    .clk          (clk),
    .reset        (reset),
    .pc           (pc),
    .instruction  (instruction),
    .instr_valid  (instr_valid),
    .address      (address),
    .read_enable  (read_enable),
    .read_data    (read_data),
    .read_valid   (read_valid),
    .write_enable (write_enable),
    .write_data   (write_data),
    .strb         (strb),
    .write_ready  (write_ready)
  );

  always #5 clk = ~clk;

  always @(negedge clk) begin
    if (write_ready === 1'b1) begin
      ready_pulses++;
    end
  end

  reset_quiet: assert property (@(posedge clk)
    reset |=> !instr_valid && !read_valid && !write_ready)
  else begin
    protocol_errors++;
    $display("a completion signal was high right after a reset cycle at %0t", $time);
  end

  write_ready_pulse: assert property (@(posedge clk) disable iff (reset)
    write_ready |=> !write_ready)
  else begin
    protocol_errors++;
    $display("write_ready stayed high for more than one cycle at %0t", $time);
  end

  no_idle_load: assert property (@(posedge clk) disable iff (reset)
    !read_enable |-> !read_valid)
  else begin
    protocol_errors++;
    $display("read_valid was high with no load held at %0t", $time);
  end

  no_idle_store: assert property (@(posedge clk) disable iff (reset)
    !write_enable |-> !write_ready)
  else begin
    protocol_errors++;
    $display("write_ready was high with no store held at %0t", $time);
  end

  function automatic logic [31:0] next_random();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // byte offset of the wrapped word
  function automatic int word_base(logic [31:0] addr);
    return int'(addr[mem_index_width+1:2]) * 4;
  endfunction

  function automatic logic [31:0] model_word(logic [31:0] addr);
    int base;
    base = word_base(addr);
    return {model[base+3], model[base+2], model[base+1], model[base]};
  endfunction

  // each random word keeps one fixed alias, some above 4 KiB
  function automatic logic [31:0] mix_addr(int word_idx);
    return (32'(word_idx % 4) << 12) | (32'(word_idx) << 2);
  endfunction

  task automatic check_bit(input logic value, input logic expected, input string name);
    assert (value === expected)
    else begin
      value_errors++;
      $display("error at %0t: %s expected %b, got %b", $time, name, expected, value);
    end
  endtask

  task automatic store(input logic [31:0] addr, input logic [31:0] data,
                       input logic [3:0] lanes);
    int base;
    address = addr;
    write_data = data;
    strb = lanes;
    write_enable = 1'b1;
    #1;
    while (write_ready !== 1'b1) @(negedge clk);
    base = word_base(addr);
    for (int i = 0; i < strb_width; i++) begin
      if (lanes[i]) begin
        model[base+i] = data[8*i +: 8];
      end
    end
    stores_done++;
    // hold through the rising edge that sees write_ready
    @(negedge clk);
    write_enable = 1'b0;
  endtask

  task automatic load(input logic [31:0] addr, input bit expect_hit);
    logic [31:0] expected;
    expected = model_word(addr);
    address = addr;
    read_enable = 1'b1;
    #1;
    if (expect_hit) begin
      check_bit(read_valid, 1'b1, "read_valid");
    end
    while (read_valid !== 1'b1) @(negedge clk);
    assert (read_data === expected)
    else begin
      value_errors++;
      $display("error at %0t: read_data at %h expected %h, got %h",
               $time, addr, expected, read_data);
    end
    @(negedge clk);
    read_enable = 1'b0;
  endtask

  task automatic fetch(input logic [31:0] addr, input bit expect_hit);
    logic [31:0] expected;
    expected = model_word(addr);
    pc = addr;
    #1;
    if (expect_hit) begin
      check_bit(instr_valid, 1'b1, "instr_valid");
    end
    while (instr_valid !== 1'b1) @(negedge clk);
    assert (instruction === expected)
    else begin
      value_errors++;
      $display("error at %0t: instruction at %h expected %h, got %h",
               $time, addr, expected, instruction);
    end
    @(negedge clk);
  endtask

  task automatic report_counts();
    $display("errors: %0d value, %0d protocol, %0d stores, %0d write_ready pulses",
             value_errors, protocol_errors, stores_done, ready_pulses);
  endtask

  initial begin
    logic [31:0] r;
    int          word_idx;
    clk = 1'b0;
    reset = 1'b1;
    pc = park_pc;
    address = '0;
    read_enable = 1'b0;
    write_enable = 1'b0;
    write_data = '0;
    strb = '0;
    seed = 32'hf9f6af38;

    // reset state
    repeat (5) begin
      @(negedge clk);
      check_bit(instr_valid, 1'b0, "instr_valid");
      check_bit(read_valid, 1'b0, "read_valid");
      check_bit(write_ready, 1'b0, "write_ready");
    end
    reset = 1'b0;
    repeat (4) begin
      @(negedge clk);
      check_bit(read_valid, 1'b0, "read_valid");
      check_bit(write_ready, 1'b0, "write_ready");
    end

    // full-word stores, then miss and hit loads
    for (int i = 0; i < 8; i++) begin
      store(32'h400 + 32'(i) * 8, next_random(), 4'hf);
    end
    for (int i = 0; i < 8; i++) begin
      load(32'h400 + 32'(i) * 8, 1'b0);
      load(32'h400 + 32'(i) * 8, 1'b1);
    end

    // 0x500 cached, 0x504 not, 0x540 shares the line of 0x500
    store(32'h500, next_random(), 4'hf);
    store(32'h540, next_random(), 4'hf);
    store(32'h504, next_random(), 4'hf);
    load(32'h500, 1'b0);
    store(32'h500, next_random(), 4'b0101);
    load(32'h500, 1'b1);
    load(32'h540, 1'b0);
    load(32'h500, 1'b0);
    store(32'h504, next_random(), 4'b1010);
    load(32'h504, 1'b0);

    // instruction fetch of freshly stored words
    for (int i = 0; i < 8; i++) begin
      store(32'h800 + 32'(i) * 4, next_random(), 4'hf);
    end
    for (int i = 0; i < 8; i++) begin
      fetch(32'h800 + 32'(i) * 4, 1'b0);
    end
    for (int i = 0; i < 8; i++) begin
      fetch(32'h800 + 32'(i) * 4, 1'b1);
    end

    // two words 64 bytes apart fight over one line in both caches
    store(32'h900, next_random(), 4'hf);
    store(32'h940, next_random(), 4'hf);
    repeat (4) begin
      load(32'h900, 1'b0);
      fetch(32'h900, 1'b0);
      load(32'h940, 1'b0);
      fetch(32'h940, 1'b0);
    end

    // fill the random window below 4 KiB, then mix through the aliases
    for (int i = 0; i < 256; i++) begin
      store(32'(i) << 2, next_random(), 4'hf);
    end
    repeat (200) begin
      r = next_random();
      word_idx = int'(r[23:16]);
      if (r[31]) begin
        store(mix_addr(word_idx), next_random(), r[27:24]);
      end else begin
        load(mix_addr(word_idx), 1'b0);
      end
    end

    assert (ready_pulses == stores_done)
    else begin
      protocol_errors++;
      $display("write_ready pulsed %0d times for %0d stores", ready_pulses, stores_done);
    end

    report_counts();
    if (value_errors + protocol_errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // about 30 cycles per request
  initial begin
    #(total_ops * 30 * 10);
    $display("watchdog expired at %0t, a request never completed", $time);
    report_counts();
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

//--- all.f
rtl/mem_pkg.sv
rtl/axi_memory.sv
rtl/i_cache.sv
rtl/d_cache.sv
rtl/memory_subsystem.sv
verification/memory_subsystem_tb.sv

//--- Bender.yml
package:
  name: memory_subsystem

sources:
  - files:
      - rtl/mem_pkg.sv
      - rtl/axi_memory.sv
      - rtl/i_cache.sv
      - rtl/d_cache.sv
      - rtl/memory_subsystem.sv
  - target: simulation
    files:
      - verification/memory_subsystem_tb.sv
